// File: include/lpif_ll_defines.svh
// Widths shared by the LPIF link layer and the two PHY lanes
// Lane 1 carries the flit bits that are left after lane 0 is full

`ifndef LPIF_LL_DEFINES_SVH
`define LPIF_LL_DEFINES_SVH

// Width of the online and sync delay values
`define LL_DELAY_WIDTH 16

// One full-rate PHY word per lane
`define LL_PHY_WIDTH 80

// PHY word less its strobe and marker bits
`define LL_LANE_PAYLOAD 78

// Packed LPIF flit as it crosses the link
`define LL_FLIT_WIDTH 145

`endif

// File: rtl/lpif_flit_pkg.sv
// Flit layout of the LPIF link word, in its field view and its lane view
// Both views are 145 bits and share one packed union

`default_nettype none

package lpif_flit_pkg;

  `include "lpif_ll_defines.svh"

  // Flit fields, most significant first
  typedef struct packed {
    logic [3:0]   state;
    logic [1:0]   protid;
    logic [127:0] data;
    logic         dvalid;
    logic [7:0]   crc;
    logic         crc_valid;
    logic         valid;
  } lpif_flit_t;

  // Same bits cut at the lane boundary
  // Lane 0 is filled first from the low end
  typedef struct packed {
    logic [`LL_FLIT_WIDTH-`LL_LANE_PAYLOAD-1:0] lane1_bits;
    logic [`LL_LANE_PAYLOAD-1:0]                lane0_bits;
  } lane_split_t;

  ////////////////////////////////////////////////////////////////////////
  // Link word
  ////////////////////////////////////////////////////////////////////////

  // Codec side works on flit, PHY side works on lane
  typedef union packed {
    lpif_flit_t  flit;
    lane_split_t lane;
  } link_word_u;

endpackage

`default_nettype wire

// File: rtl/aib_phy_pkg.sv
// Types for one full-rate PHY lane word and its sync bits
// Strobe and marker sit at the top of the word, payload below them

`default_nettype none

package aib_phy_pkg;

  `include "lpif_ll_defines.svh"

  // Strobe and marker as sent on every lane
  typedef struct packed {
    logic stb;
    logic mrk;
  } sync_bits_t;

  ////////////////////////////////////////////////////////////////////////
  // Lane word
  ////////////////////////////////////////////////////////////////////////

  // 80 bits in total
  // Short lanes keep their bits at the low end of payload
  typedef struct packed {
    logic                        stb;
    logic                        mrk;
    logic [`LL_LANE_PAYLOAD-1:0] payload;
  } phy_word_t;

endpackage

`default_nettype wire

// File: rtl/ll_auto_sync.sv
// Delays tx/rx online and forces strobe and marker on for a sync window
// A delay of 0 raises the online level at the edge that first sees online high
// Dropping online clears the level and the window at the next edge

`timescale 1ns/10ps
`default_nettype none

`include "lpif_ll_defines.svh"

module ll_auto_sync
  import aib_phy_pkg::*;
(
  input  logic                       clk_wr,
  input  logic                       reset,

  input  logic                       tx_online,
  input  logic                       rx_online,
  input  logic                       tx_stb_userbit,
  input  logic                       tx_mrk_userbit,

  input  logic [`LL_DELAY_WIDTH-1:0] delay_x_value,
  input  logic [`LL_DELAY_WIDTH-1:0] delay_y_value,
  input  logic [`LL_DELAY_WIDTH-1:0] delay_z_value,

  output logic                       tx_online_delay,
  output logic                       rx_online_delay,
  output sync_bits_t                 tx_sync
);

  // Count and level of one online delay
  typedef struct packed {
    logic [`LL_DELAY_WIDTH-1:0] cnt;
    logic                       level;
  } delay_state_t;

  delay_state_t               tx_state;
  delay_state_t               rx_state;
  delay_state_t               tx_next;
  delay_state_t               rx_next;
  logic [`LL_DELAY_WIDTH-1:0] win_cnt;
  logic                       in_win;

  // One step of a delay counter
  // Counts up while online, sets the level once the limit is reached
  function automatic delay_state_t delay_step(
    input delay_state_t               cur,
    input logic                       online,
    input logic [`LL_DELAY_WIDTH-1:0] limit
  );
    delay_state_t nxt;
    nxt = cur;
    if (!online) begin
      nxt = '0;
    end else if (!cur.level) begin
      if (cur.cnt >= limit) begin
        nxt.level = 1'b1;
      end else begin
        nxt.cnt = cur.cnt + 1'b1;
      end
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Online delays

  always_comb begin
    tx_next = delay_step(tx_state, tx_online, delay_y_value);
    rx_next = delay_step(rx_state, rx_online, delay_x_value);
  end

  assign tx_online_delay = tx_state.level;
  assign rx_online_delay = rx_state.level;

  //////////////////////////////////////////////////////////////////////
  // Sync window

  // win_cnt sits at zero until tx goes online, so window starts clean
  assign in_win = (win_cnt < delay_z_value);

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_state <= '0;
      rx_state <= '0;
      win_cnt  <= '0;
      tx_sync  <= '0;
    end else begin
      tx_state <= tx_next;
      rx_state <= rx_next;
      if (!tx_next.level) begin
        win_cnt <= '0;
        tx_sync <= '0;
      end else if (in_win) begin
        // Forced on while the far end aligns
        win_cnt <= win_cnt + 1'b1;
        tx_sync <= '{stb: 1'b1, mrk: 1'b1};
      end else begin
        tx_sync <= '{stb: tx_stb_userbit, mrk: tx_mrk_userbit};
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/lpif_flit_codec.sv
// Packs downstream LPIF fields into the link word and unpacks the upstream word
// One cycle each way, a new flit may enter every cycle, no handshake

`timescale 1ns/10ps
`default_nettype none

module lpif_flit_codec
  import lpif_flit_pkg::*;
(
  input  logic         clk_wr,
  input  logic         reset,

  // Downstream channel
  input  logic [3:0]   dstrm_state,
  input  logic [1:0]   dstrm_protid,
  input  logic [127:0] dstrm_data,
  input  logic         dstrm_dvalid,
  input  logic [7:0]   dstrm_crc,
  input  logic         dstrm_crc_valid,
  input  logic         dstrm_valid,

  // Link words
  input  link_word_u   rx_word,
  output link_word_u   tx_word,

  // Upstream channel
  output logic [3:0]   ustrm_state,
  output logic [1:0]   ustrm_protid,
  output logic [127:0] ustrm_data,
  output logic         ustrm_dvalid,
  output logic [7:0]   ustrm_crc,
  output logic         ustrm_crc_valid,
  output logic         ustrm_valid
);

  //////////////////////////////////////////////////////////////////////
  // Transmit pack

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_word <= '0;
    end else begin
      // Written through the field view
      tx_word.flit <= '{state:     dstrm_state,
                        protid:    dstrm_protid,
                        data:      dstrm_data,
                        dvalid:    dstrm_dvalid,
                        crc:       dstrm_crc,
                        crc_valid: dstrm_crc_valid,
                        valid:     dstrm_valid};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive unpack

  // rx_word is already blanked while rx side is offline
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_valid     <= 1'b0;
    end else begin
      ustrm_state     <= rx_word.flit.state;
      ustrm_protid    <= rx_word.flit.protid;
      ustrm_data      <= rx_word.flit.data;
      ustrm_dvalid    <= rx_word.flit.dvalid;
      ustrm_crc       <= rx_word.flit.crc;
      ustrm_crc_valid <= rx_word.flit.crc_valid;
      ustrm_valid     <= rx_word.flit.valid;
    end
  end

endmodule

`default_nettype wire

// File: rtl/phy_lane_concat.sv
// Splits the 145-bit link word over two full-rate PHY lanes and rebuilds it
// Lane 1 payload carries 67 bits at the low end, its top 11 bits are sent as zero
// Received sync bits and the unused lane 1 bits are dropped

`timescale 1ns/10ps
`default_nettype none

`include "lpif_ll_defines.svh"

module phy_lane_concat
  import lpif_flit_pkg::*;
  import aib_phy_pkg::*;
(
  input  logic       clk_wr,
  input  logic       reset,

  input  link_word_u tx_word,
  input  sync_bits_t tx_sync,
  input  logic       tx_online_delay,
  input  logic       rx_online_delay,

  input  phy_word_t  rx_phy0,
  input  phy_word_t  rx_phy1,

  output phy_word_t  tx_phy0,
  output phy_word_t  tx_phy1,
  output link_word_u rx_word
);

  // Bits of the flit that spill into lane 1
  localparam int LANE1_BITS = `LL_FLIT_WIDTH - `LL_LANE_PAYLOAD;
  // Unused top of lane 1 payload
  localparam int LANE1_PAD  = `LL_LANE_PAYLOAD - LANE1_BITS;

  //////////////////////////////////////////////////////////////////////
  // Transmit lanes

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (!tx_online_delay) begin
      // Quiet lanes until tx side is online
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      // Same sync bits on both lanes
      tx_phy0 <= '{stb:     tx_sync.stb,
                   mrk:     tx_sync.mrk,
                   payload: tx_word.lane.lane0_bits};
      tx_phy1 <= '{stb:     tx_sync.stb,
                   mrk:     tx_sync.mrk,
                   payload: {{LANE1_PAD{1'b0}}, tx_word.lane.lane1_bits}};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive lanes

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_word <= '0;
    end else if (!rx_online_delay) begin
      // Nothing reaches the codec while rx side is offline
      rx_word <= '0;
    end else begin
      rx_word.lane <= '{lane1_bits: rx_phy1.payload[LANE1_BITS-1:0],
                        lane0_bits: rx_phy0.payload};
    end
  end

endmodule

`default_nettype wire

// File: rtl/lpif_ll_master_top.sv
// Master side of a two-lane LPIF link over full-rate PHY lanes
// Logic link FIFO and credits are bypassed, valids travel as plain levels
// Two cycles from dstrm to tx_phy and from rx_phy to ustrm

`timescale 1ns/10ps
`default_nettype none

`include "lpif_ll_defines.svh"

module lpif_ll_master_top
  import lpif_flit_pkg::*;
  import aib_phy_pkg::*;
(
  input  logic                       clk_wr,
  input  logic                       reset,

  // Control
  input  logic                       tx_online,
  input  logic                       rx_online,

  // Configuration
  input  logic [`LL_DELAY_WIDTH-1:0] delay_x_value,
  input  logic [`LL_DELAY_WIDTH-1:0] delay_y_value,
  input  logic [`LL_DELAY_WIDTH-1:0] delay_z_value,
  input  logic                       tx_stb_userbit,
  input  logic                       tx_mrk_userbit,

  // Downstream channel
  input  logic [3:0]                 dstrm_state,
  input  logic [1:0]                 dstrm_protid,
  input  logic [127:0]               dstrm_data,
  input  logic                       dstrm_dvalid,
  input  logic [7:0]                 dstrm_crc,
  input  logic                       dstrm_crc_valid,
  input  logic                       dstrm_valid,

  // Upstream channel
  output logic [3:0]                 ustrm_state,
  output logic [1:0]                 ustrm_protid,
  output logic [127:0]               ustrm_data,
  output logic                       ustrm_dvalid,
  output logic [7:0]                 ustrm_crc,
  output logic                       ustrm_crc_valid,
  output logic                       ustrm_valid,

  // PHY interconnect
  output logic [`LL_PHY_WIDTH-1:0]   tx_phy0,
  output logic [`LL_PHY_WIDTH-1:0]   tx_phy1,
  input  logic [`LL_PHY_WIDTH-1:0]   rx_phy0,
  input  logic [`LL_PHY_WIDTH-1:0]   rx_phy1
);

  ////////////////////////////////////////////////////////////////////////
  // Interconnect

  sync_bits_t tx_sync;
  logic       tx_online_delay;
  logic       rx_online_delay;
  link_word_u tx_word;
  link_word_u rx_word;

  ////////////////////////////////////////////////////////////////////////
  // Auto sync

  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_sync         (tx_sync)
  );

  ////////////////////////////////////////////////////////////////////////
  // Flit codec

  lpif_flit_codec u_codec (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_word         (rx_word),
    .tx_word         (tx_word),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  ////////////////////////////////////////////////////////////////////////
  // PHY lanes

  // Flat 80-bit ports map straight onto phy_word_t
  phy_lane_concat u_concat (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_word         (tx_word),
    .tx_sync         (tx_sync),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_word         (rx_word)
  );

endmodule

`default_nettype wire

// File: verif/lpif_ll_tb.sv
// Loopback testbench for the LPIF link master, tx_phy wired back to rx_phy
// Model steps once per clock from the history of driven inputs
// Delay values are drawn once after seeding and held for the whole run

`timescale 1ns/10ps
`default_nettype none

`include "lpif_ll_defines.svh"

module lpif_ll_tb
  import lpif_flit_pkg::*;
  import aib_phy_pkg::*;
();

  // All DUT inputs of one cycle
  typedef struct packed {
    logic       rst;
    logic       tx_on;
    logic       rx_on;
    sync_bits_t usr;
    lpif_flit_t flit;
  } stim_t;

  logic                       clk_wr = 1'b0;
  logic                       reset;
  logic                       tx_online;
  logic                       rx_online;
  logic                       tx_stb_userbit;
  logic                       tx_mrk_userbit;
  logic [`LL_DELAY_WIDTH-1:0] delay_x_value;
  logic [`LL_DELAY_WIDTH-1:0] delay_y_value;
  logic [`LL_DELAY_WIDTH-1:0] delay_z_value;
  logic [3:0]                 dstrm_state, ustrm_state;
  logic [1:0]                 dstrm_protid, ustrm_protid;
  logic [127:0]               dstrm_data, ustrm_data;
  logic                       dstrm_dvalid, ustrm_dvalid;
  logic [7:0]                 dstrm_crc, ustrm_crc;
  logic                       dstrm_crc_valid, ustrm_crc_valid;
  logic                       dstrm_valid, ustrm_valid;
  logic [`LL_PHY_WIDTH-1:0]   tx_phy0;
  logic [`LL_PHY_WIDTH-1:0]   tx_phy1;

  int         dly_x;
  int         dly_y;
  int         dly_z;
  int         wd_cycles = 0;
  int         err_count = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  string      cur_test;
  // Entry 0 holds the inputs sampled at the latest edge
  stim_t      hist[$];

  // Model state after the latest edge
  int         tx_run;
  int         rx_run;
  logic       tx_lvl;
  logic       rx_lvl;
  sync_bits_t sync_m;
  phy_word_t  phy0_m;
  phy_word_t  phy1_m;
  lpif_flit_t rx_m;
  lpif_flit_t ustrm_m;

  always #5 clk_wr = ~clk_wr;

  // Loopback on the PHY side
  lpif_ll_master_top DUT (.*, .rx_phy0(tx_phy0), .rx_phy1(tx_phy1));

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_flit(input string what, input lpif_flit_t exp, input lpif_flit_t act);
    if (act !== exp) begin
      err_count++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_phy(input string what, input phy_word_t exp, input phy_word_t act);
    if (act !== exp) begin
      err_count++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and model

  function automatic lpif_flit_t rand_flit();
    lpif_flit_t f;
    f.state     = 4'($urandom());
    f.protid    = 2'($urandom());
    f.data      = {$urandom(), $urandom(), $urandom(), $urandom()};
    f.dvalid    = 1'($urandom());
    f.crc       = 8'($urandom());
    f.crc_valid = 1'($urandom());
    f.valid     = 1'($urandom());
    return f;
  endfunction

  task automatic drive_inputs(input stim_t s);
    reset           <= s.rst;
    tx_online       <= s.tx_on;
    rx_online       <= s.rx_on;
    tx_stb_userbit  <= s.usr.stb;
    tx_mrk_userbit  <= s.usr.mrk;
    dstrm_state     <= s.flit.state;
    dstrm_protid    <= s.flit.protid;
    dstrm_data      <= s.flit.data;
    dstrm_dvalid    <= s.flit.dvalid;
    dstrm_crc       <= s.flit.crc;
    dstrm_crc_valid <= s.flit.crc_valid;
    dstrm_valid     <= s.flit.valid;
  endtask

  // One clock edge of the expected link behaviour
  function automatic void model_edge();
    stim_t                        s;
    logic [2*`LL_LANE_PAYLOAD-1:0] both;
    s = hist[0];
    if (s.rst) begin
      tx_run = 0;
      rx_run = 0;
      {tx_lvl, rx_lvl, sync_m, phy0_m, phy1_m, rx_m, ustrm_m} = '0;
    end else begin
      // Later stages first so each reads the previous edge
      ustrm_m = rx_m;
      both = {phy1_m.payload, phy0_m.payload};
      rx_m = rx_lvl ? both[`LL_FLIT_WIDTH-1:0] : '0;
      // Lanes are back to back slices of the zero extended flit
      both = '0;
      both[`LL_FLIT_WIDTH-1:0] = hist[1].flit;
      phy0_m = '{stb: sync_m.stb, mrk: sync_m.mrk, payload: both[`LL_LANE_PAYLOAD-1:0]};
      phy1_m = '{stb: sync_m.stb, mrk: sync_m.mrk,
                 payload: both[2*`LL_LANE_PAYLOAD-1:`LL_LANE_PAYLOAD]};
      if (!tx_lvl) begin
        phy0_m = '0;
        phy1_m = '0;
      end
      tx_run = s.tx_on ? tx_run + 1 : 0;
      rx_run = s.rx_on ? rx_run + 1 : 0;
      tx_lvl = (tx_run > dly_y);
      rx_lvl = (rx_run > dly_x);
      // Forced on for the first dly_z edges of the online level
      if (!tx_lvl) begin
        sync_m = '0;
      end else if (tx_run <= dly_y + dly_z) begin
        sync_m = '{stb: 1'b1, mrk: 1'b1};
      end else begin
        sync_m = s.usr;
      end
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Cycle and test runners

  // Drive on the rising edge, check at the falling edge
  task automatic run_cycle(input stim_t s, input bit loop);
    lpif_flit_t up;
    phy_word_t  p0;
    phy_word_t  p1;
    @(posedge clk_wr);
    drive_inputs(s);
    @(negedge clk_wr);
    model_edge();
    up = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
          ustrm_crc, ustrm_crc_valid, ustrm_valid};
    p0 = phy_word_t'(tx_phy0);
    p1 = phy_word_t'(tx_phy1);
    check_phy("tx_phy0", phy0_m, p0);
    check_phy("tx_phy1", phy1_m, p1);
    check_bit("tx_phy1 pad", 1'b0,
              |p1.payload[`LL_LANE_PAYLOAD-1:`LL_FLIT_WIDTH-`LL_LANE_PAYLOAD]);
    check_flit("ustrm", ustrm_m, up);
    // Flit driven four edges back
    if (loop) check_flit("ustrm vs dstrm", hist[3].flit, up);
    hist.push_front(s);
    void'(hist.pop_back());
  endtask

  task automatic run_test(input string name, input int cycles, input bit rst,
                          input bit tx_on, input bit rx_on, input bit loop);
    stim_t s;
    int    errs0;
    errs0    = err_count;
    cur_test = name;
    repeat (cycles) begin
      s       = '{rst: rst, tx_on: tx_on, rx_on: rx_on, usr: '0, flit: '0};
      s.usr   = '{stb: 1'($urandom()), mrk: 1'($urandom())};
      s.flit  = rand_flit();
      run_cycle(s, loop);
    end
    tests_run++;
    if (err_count != errs0) tests_failed++;
    $display("test %s: %0d cycles, %0d errors", name, cycles, err_count - errs0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    stim_t idle;
    void'($urandom(32'he830df13));
    dly_x = $urandom_range(20, 1);
    dly_y = $urandom_range(20, 1);
    dly_z = $urandom_range(16, 1);
    // Sum of the test lengths below plus margin
    wd_cycles = 10 + (dly_y + 3) + (dly_z + 20) + 50 + (dly_x + 4) + 300 + 50;
    idle      = '0;
    idle.rst  = 1'b1;
    repeat (4) hist.push_back(idle);
    drive_inputs(idle);
    delay_x_value = dly_x[`LL_DELAY_WIDTH-1:0];
    delay_y_value = dly_y[`LL_DELAY_WIDTH-1:0];
    delay_z_value = dly_z[`LL_DELAY_WIDTH-1:0];
    run_test("reset", 10, 1'b1, 1'b0, 1'b0, 1'b0);
    run_test("online_delay", dly_y + 3, 1'b0, 1'b1, 1'b0, 1'b0);
    run_test("sync_window", dly_z + 20, 1'b0, 1'b1, 1'b0, 1'b0);
    run_test("lane_map", 50, 1'b0, 1'b1, 1'b0, 1'b0);
    run_test("rx_gating", dly_x + 4, 1'b0, 1'b1, 1'b1, 1'b0);
    run_test("loopback", 300, 1'b0, 1'b1, 1'b1, 1'b1);
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    #(wd_cycles * 10);
    $display("Timeout, the tests did not finish within %0d cycles", wd_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/lpif_flit_pkg.sv
rtl/aib_phy_pkg.sv
rtl/ll_auto_sync.sv
rtl/lpif_flit_codec.sv
rtl/phy_lane_concat.sv
rtl/lpif_ll_master_top.sv
verif/lpif_ll_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := lpif_ll_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := RESULT: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
